/* verilog/arf_pkg.sv */
package arf_pkg;

   localparam int REG_NUM  = 32;   // architectural registers
   localparam int REG_SEL  = 5;
   localparam int DATA_LEN = 32;
   localparam int RRF_SEL  = 6;    // rename buffer tag width
   localparam int SRC_NUM  = 4;    // read ports, two per dispatch slot

   typedef logic [REG_SEL-1:0]  reg_idx_t;
   typedef logic [DATA_LEN-1:0] data_t;
   typedef logic [RRF_SEL-1:0]  rrf_tag_t;

   // source indices of both dispatch slots, slot 1 first
   typedef struct packed {
      reg_idx_t rs1_1;
      reg_idx_t rs2_1;
      reg_idx_t rs1_2;
      reg_idx_t rs2_2;
   } src_regs_t;

   // dispatch marks dst busy under a new tag
   typedef struct packed {
      logic     valid;
      reg_idx_t dst;
      rrf_tag_t tag;
   } rename_set_t;

   // retirement of one rename buffer entry
   typedef struct packed {
      logic     valid;
      reg_idx_t dst;
      rrf_tag_t tag;    // producer tag being retired
      data_t    data;
   } commit_t;

   // what a consumer sees for one source
   typedef struct packed {
      data_t    data;
      rrf_tag_t tag;
      logic     busy;   // value still in the rename buffer
   } operand_t;

endpackage

/* verilog/multiport_array.sv */
`timescale 1ns/1ns

module multiport_array #(
   parameter type entry_t = arf_pkg::data_t
) (
   input  logic               clk,
   input  logic               reset,
   input  arf_pkg::src_regs_t raddr,
   output entry_t             rdata [arf_pkg::SRC_NUM],
   input  logic               we1,
   input  logic               we2,
   input  arf_pkg::reg_idx_t  waddr1,
   input  arf_pkg::reg_idx_t  waddr2,
   input  entry_t             wdata1,
   input  entry_t             wdata2
);

   import arf_pkg::*;

   entry_t   mem [REG_NUM];
   reg_idx_t rd_idx [SRC_NUM];

   // port order follows the source struct
   assign rd_idx[0] = raddr.rs1_1;
   assign rd_idx[1] = raddr.rs2_1;
   assign rd_idx[2] = raddr.rs1_2;
   assign rd_idx[3] = raddr.rs2_2;

   always_comb begin
      for (int i = 0; i < SRC_NUM; i++) begin
         rdata[i] = mem[rd_idx[i]];   // no bypass of same-cycle writes
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < REG_NUM; i++) begin
            mem[i] <= '0;
         end
      end else begin
         if (we1) begin
            mem[waddr1] <= wdata1;
         end
         // second port is newer in program order
         if (we2) begin
            mem[waddr2] <= wdata2;   // overrides port 1 on a clash
         end
      end
   end

   a_waddr1_known : assert property (
      @(posedge clk) disable iff (reset)
      we1 |-> !$isunknown(waddr1)
   ) else $error("multiport_array: waddr1 unknown with we1 high");

   a_waddr2_known : assert property (
      @(posedge clk) disable iff (reset)
      we2 |-> !$isunknown(waddr2)
   ) else $error("multiport_array: waddr2 unknown with we2 high");

endmodule

/* verilog/rename_table.sv */
`timescale 1ns/1ns

module rename_table (
   input  logic                 clk,
   input  logic                 reset,
   input  arf_pkg::src_regs_t   src,
   input  arf_pkg::rename_set_t set1,
   input  arf_pkg::rename_set_t set2,
   input  arf_pkg::commit_t     com1,
   input  arf_pkg::commit_t     com2,
   output arf_pkg::rrf_tag_t    src_tag [arf_pkg::SRC_NUM],
   output logic [arf_pkg::SRC_NUM-1:0] src_busy
);

   import arf_pkg::*;

   logic [REG_NUM-1:0] busy_q;
   src_regs_t          com_addr;
   rrf_tag_t           com_tag [SRC_NUM];
   logic               set_hits_com1;
   logic               set_hits_com2;
   logic               clr1;
   logic               clr2;

   // newest producer per register, slot 2 wins a shared dst
   multiport_array #(
      .entry_t (rrf_tag_t)
   ) u_tag (
      .clk    (clk),
      .reset  (reset),
      .raddr  (src),
      .rdata  (src_tag),
      .we1    (set1.valid),
      .we2    (set2.valid),
      .waddr1 (set1.dst),
      .waddr2 (set2.dst),
      .wdata1 (set1.tag),
      .wdata2 (set2.tag)
   );

   // replica of the tag store for the commit lookups
   // upper two ports mirror the lower two
   assign com_addr = '{
      rs1_1: com1.dst,
      rs2_1: com2.dst,
      rs1_2: com1.dst,
      rs2_2: com2.dst
   };

   multiport_array #(
      .entry_t (rrf_tag_t)
   ) u_tag_com (
      .clk    (clk),
      .reset  (reset),
      .raddr  (com_addr),
      .rdata  (com_tag),
      .we1    (set1.valid),
      .we2    (set2.valid),
      .waddr1 (set1.dst),
      .waddr2 (set2.dst),
      .wdata1 (set1.tag),
      .wdata2 (set2.tag)
   );

   // a fresh rename of the same register keeps it busy
   assign set_hits_com1 = (set1.valid && (set1.dst == com1.dst)) ||
                          (set2.valid && (set2.dst == com1.dst));
   assign set_hits_com2 = (set1.valid && (set1.dst == com2.dst)) ||
                          (set2.valid && (set2.dst == com2.dst));

   // only the newest producer may release the register
   assign clr1 = com1.valid && (com_tag[0] == com1.tag) && !set_hits_com1;
   assign clr2 = com2.valid && (com_tag[1] == com2.tag) && !set_hits_com2;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy_q <= '0;
      end else begin
         if (clr1) begin
            busy_q[com1.dst] <= 1'b0;
         end
         if (clr2) begin
            busy_q[com2.dst] <= 1'b0;
         end
         if (set1.valid) begin
            busy_q[set1.dst] <= 1'b1;
         end
         if (set2.valid) begin
            busy_q[set2.dst] <= 1'b1;
         end
      end
   end

   assign src_busy[0] = busy_q[src.rs1_1];
   assign src_busy[1] = busy_q[src.rs2_1];
   assign src_busy[2] = busy_q[src.rs1_2];
   assign src_busy[3] = busy_q[src.rs2_2];

   a_set1_busy : assert property (
      @(posedge clk) disable iff (reset)
      set1.valid |=> busy_q[$past(set1.dst)]
   ) else $error("rename_table: set1 register not busy after set");

   a_set2_busy : assert property (
      @(posedge clk) disable iff (reset)
      set2.valid |=> busy_q[$past(set2.dst)]
   ) else $error("rename_table: set2 register not busy after set");

endmodule

/* verilog/arf.sv */
`timescale 1ns/1ns

module arf (
   input  logic                 clk,
   input  logic                 reset,
   input  arf_pkg::src_regs_t   src,
   input  arf_pkg::rename_set_t set1,
   input  arf_pkg::rename_set_t set2,
   input  arf_pkg::commit_t     com1,
   input  arf_pkg::commit_t     com2,
   output arf_pkg::operand_t    operand [arf_pkg::SRC_NUM]
);

   import arf_pkg::*;

   data_t              src_data [SRC_NUM];
   rrf_tag_t           src_tag [SRC_NUM];
   logic [SRC_NUM-1:0] src_busy;
   logic               data_we1;
   logic               data_we2;

   // r0 is hardwired and never written
   assign data_we1 = com1.valid && (com1.dst != '0);
   assign data_we2 = com2.valid && (com2.dst != '0);

   multiport_array #(
      .entry_t (data_t)
   ) u_data (
      .clk    (clk),
      .reset  (reset),
      .raddr  (src),
      .rdata  (src_data),
      .we1    (data_we1),
      .we2    (data_we2),
      .waddr1 (com1.dst),
      .waddr2 (com2.dst),
      .wdata1 (com1.data),
      .wdata2 (com2.data)
   );

   rename_table u_rename (
      .clk      (clk),
      .reset    (reset),
      .src      (src),
      .set1     (set1),
      .set2     (set2),
      .com1     (com1),
      .com2     (com2),
      .src_tag  (src_tag),
      .src_busy (src_busy)
   );

   always_comb begin
      for (int i = 0; i < SRC_NUM; i++) begin
         operand[i] = '{
            data: src_data[i],
            tag:  src_tag[i],
            busy: src_busy[i]
         };
      end
   end

endmodule

/* verif/arf_checker.sv */
`timescale 1ns/1ns

module arf_checker (
   input  logic              clk,
   input  logic              check_en,
   input  logic              test_end,
   input  int                test_id,
   input  arf_pkg::operand_t operand [arf_pkg::SRC_NUM],
   input  arf_pkg::operand_t expected [arf_pkg::SRC_NUM],
   output int                err_count,
   output int                tests_run,
   output int                tests_bad
);

   import arf_pkg::*;

   int errs = 0;
   int runs = 0;
   int bad = 0;
   int test_errs = 0;
   int cycles = 0;   // checked cycles in the current test

   assign err_count = errs;
   assign tests_run = runs;
   assign tests_bad = bad;

   task automatic compare_field(input string field, input int slot,
                                input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("error test %0d: operand[%0d].%s got %h expected %h",
                  test_id, slot, field, got, want);
         errs++;
         test_errs++;
      end
   endtask

   // mid-cycle, inputs settled since the rising edge
   always @(negedge clk) begin
      if (check_en) begin
         cycles++;
         for (int i = 0; i < SRC_NUM; i++) begin
            compare_field("data", i, operand[i].data, expected[i].data);
            compare_field("tag", i, 32'(operand[i].tag), 32'(expected[i].tag));
            compare_field("busy", i, 32'(operand[i].busy), 32'(expected[i].busy));
         end
         if (test_end) begin
            if (test_errs == 0) begin
               $display("test %0d ok, %0d cycles checked", test_id, cycles);
            end else begin
               $display("test %0d bad, %0d mismatches in %0d cycles",
                        test_id, test_errs, cycles);
               bad++;
            end
            runs++;
            test_errs = 0;
            cycles = 0;
         end
      end
   end

endmodule

/* verif/tb_arf.sv */
`timescale 1ns/1ns

module tb_arf;

   import arf_pkg::*;

   localparam int CLK_HALF   = 2;
   localparam int CLK_PERIOD = 2 * CLK_HALF;
   localparam int MAX_LINES  = 256;

   logic        clk = 1'b0;
   logic        reset;
   src_regs_t   src;
   rename_set_t set1;
   rename_set_t set2;
   commit_t     com1;
   commit_t     com2;
   operand_t    operand [SRC_NUM];

   operand_t    exp_op [SRC_NUM];   // handed to the checker with each line
   logic        check_en;
   logic        test_end;
   int          test_id;
   int          err_count;
   int          tests_run;
   int          tests_bad;

   // stimulus table, one entry per file line
   int          line_test [MAX_LINES];
   src_regs_t   line_src  [MAX_LINES];
   rename_set_t line_set1 [MAX_LINES];
   rename_set_t line_set2 [MAX_LINES];
   commit_t     line_com1 [MAX_LINES];
   commit_t     line_com2 [MAX_LINES];
   operand_t    line_exp  [MAX_LINES][SRC_NUM];
   int          n_lines = 0;
   int          n_tests = 0;
   logic        loaded = 1'b0;
   logic [31:0] lfsr = 32'h5e6b9041;

   arf u_dut (
      .clk     (clk),
      .reset   (reset),
      .src     (src),
      .set1    (set1),
      .set2    (set2),
      .com1    (com1),
      .com2    (com2),
      .operand (operand)
   );

   arf_checker u_check (
      .clk       (clk),
      .check_en  (check_en),
      .test_end  (test_end),
      .test_id   (test_id),
      .operand   (operand),
      .expected  (exp_op),
      .err_count (err_count),
      .tests_run (tests_run),
      .tests_bad (tests_bad)
   );

   always #CLK_HALF clk = ~clk;

   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h80200003;
      end
      return state >> 1;
   endfunction

   // idle gap of 0 to 3 cycles, one step per bit
   task automatic pick_idle(output int count);
      lfsr = lfsr_step(lfsr);
      count = int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
      count = count + 2 * int'(lfsr[0]);
   endtask

   task automatic drive_idle();
      src      <= '0;
      set1     <= '0;
      set2     <= '0;
      com1     <= '0;
      com2     <= '0;
      check_en <= 1'b0;
      test_end <= 1'b0;
   endtask

   task automatic load_stimulus(output bit ok);
      int          fd;
      int          n;
      int          tnum;
      int          prev_test;
      string       text;
      logic [19:0] s;
      logic [11:0] a;
      logic [11:0] b;
      logic [43:0] c;
      logic [43:0] d;
      logic [3:0]  bm;
      logic [7:0]  t [SRC_NUM];
      logic [31:0] v [SRC_NUM];
      ok = 1'b1;
      prev_test = -1;
      fd = $fopen("verif/arf_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open verif/arf_stimulus.txt");
         ok = 1'b0;
      end else begin
         while ($fgets(text, fd) != 0) begin
            if (text.len() > 1 && text[0] != "#") begin
               n = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           tnum, s, a, b, c, d, bm, t[0], t[1], t[2], t[3],
                           v[0], v[1], v[2], v[3]);
               if (n != 15 || n_lines == MAX_LINES) begin
                  $display("bad or excess stimulus line: %s", text);
                  ok = 1'b0;
               end else begin
                  line_test[n_lines] = tnum;
                  line_src[n_lines]  = s;
                  line_set1[n_lines] = a;
                  line_set2[n_lines] = b;
                  line_com1[n_lines] = c;
                  line_com2[n_lines] = d;
                  for (int p = 0; p < SRC_NUM; p++) begin
                     line_exp[n_lines][p] = '{data: v[p], tag: t[p][RRF_SEL-1:0], busy: bm[p]};
                  end
                  if (tnum != prev_test) begin
                     n_tests++;
                  end
                  prev_test = tnum;
                  n_lines++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      bit ok;
      int idle;
      bit last;
      reset   <= 1'b1;
      test_id <= 0;
      exp_op  <= '{default: '0};
      drive_idle();
      load_stimulus(ok);
      if (!ok) begin
         $display("tests failed");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (5) @(posedge clk);
         reset <= 1'b0;
         for (int i = 0; i < n_lines; i++) begin
            last = (i == n_lines - 1);
            if (!last) begin
               last = (line_test[i + 1] != line_test[i]);
            end
            @(posedge clk);
            src      <= line_src[i];
            set1     <= line_set1[i];
            set2     <= line_set2[i];
            com1     <= line_com1[i];
            com2     <= line_com2[i];
            exp_op   <= line_exp[i];
            test_id  <= line_test[i];
            check_en <= 1'b1;
            test_end <= last;
            if (last) begin
               pick_idle(idle);
               repeat (idle) begin
                  @(posedge clk);
                  drive_idle();
               end
            end
         end
         @(posedge clk);
         drive_idle();
         @(posedge clk);
         if (tests_run != n_tests) begin
            $display("only %0d of %0d tests reached the checker", tests_run, n_tests);
         end
         $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                  n_tests, tests_run - tests_bad, tests_bad, err_count);
         if (n_tests > 0 && err_count == 0 && tests_bad == 0 && tests_run == n_tests) begin
            $display("all tests passed");
         end else begin
            $display("tests failed");
         end
         $finish;
      end
   end

   // watchdog, limit scales with the stimulus length
   initial begin
      wait (loaded);
      #((n_lines + 4 * n_tests + 20) * CLK_PERIOD);
      $display("timeout: run did not complete within %0d cycles", n_lines + 4 * n_tests + 20);
      $display("tests failed");
      $finish;
   end

endmodule

/* verif/arf_stimulus.txt */
# test src set1 set2 com1 com2 busy tag0 tag1 tag2 tag3 data0 data1 data2 data3 (test decimal, rest hex)
# src={rs1_1,rs2_1,rs1_2,rs2_2} set={valid,dst,tag} com={valid,dst,tag,data} busy bit i = port i
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 fffff 0 0 0 0 0 0 0 0 0 0 0 0 0
1 8805 0 0 0 0 0 0 0 0 0 0 0 0 0
2 294a5 0 0 94112345678 0 0 0 0 0 0 0 0 0 0
2 294a5 0 0 800cafef00d 800deadbeef 0 0 0 0 0 12345678 12345678 12345678 12345678
2 1405 0 0 0 0 0 0 0 0 0 0 12345678 0 12345678
3 39ce7 0 0 9c211111111 9c322222222 0 0 0 0 0 0 0 0 0
3 39ce7 0 0 0 0 0 0 0 0 0 22222222 22222222 22222222 22222222
4 5294a a95 0 0 0 0 0 0 0 0 0 0 0 0
4 5294a 0 aaa 0 0 f 15 15 15 15 0 0 0 0
4 5294a 0 0 a95aaaa5555 0 f 2a 2a 2a 2a 0 0 0 0
4 5294a 0 0 0 0 f 2a 2a 2a 2a aaaa5555 aaaa5555 aaaa5555 aaaa5555
4 5294a 0 0 0 aaa0badf00d f 2a 2a 2a 2a aaaa5555 aaaa5555 aaaa5555 aaaa5555
4 5294a 0 0 0 0 0 2a 2a 2a 2a badf00d badf00d badf00d badf00d
5 18c63 8c7 0 0 0 0 0 0 0 0 0 0 0 0
5 18c63 0 8c8 8c733333333 0 f 7 7 7 7 0 0 0 0
5 18c63 0 0 0 0 f 8 8 8 8 33333333 33333333 33333333 33333333
6 8421 871 84c 0 0 0 0 0 0 0 0 0 0 0
6 8d40 0 0 0 0 3 c 8 2a 0 0 33333333 badf00d 0

/* files.f */
verilog/arf_pkg.sv
verilog/multiport_array.sv
verilog/rename_table.sv
verilog/arf.sv
verif/arf_checker.sv
verif/tb_arf.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module tb_arf -Mdir obj_dir -o sim_arf
	obj_dir/sim_arf | awk '{ print } /^all tests passed$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert -f files.f --top-module tb_arf
	verilator --lint-only --assert verilog/arf_pkg.sv verilog/multiport_array.sv \
		verilog/rename_table.sv verilog/arf.sv --top-module arf

clean:
	rm -rf obj_dir
